//--- verilog/cache_pkg.sv
// ********************
// geometry of a 2-way, 16-set cache with 4-word blocks
// burst length equals block size, one cache word per beat
// ********************

package cache_pkg;

  localparam int addr_width  = 32;
  localparam int word_width  = 32;
  localparam int block_words = 4;
  localparam int sets        = 16;
  localparam int ways        = 2;

  // derived index widths
  localparam int way_width          = $clog2(ways);
  localparam int set_width          = $clog2(sets);
  localparam int word_offset_width  = $clog2(block_words);
  localparam int byte_offset_width  = $clog2(word_width / 8);
  localparam int block_offset_width = byte_offset_width + word_offset_width;

  // data array row is {set, word}
  localparam int mem_addr_width = set_width + word_offset_width;

  // must reach block_words, not just block_words-1
  localparam int count_width = $clog2(block_words + 1);

  typedef enum logic [2:0] {
    dma_nop,
    dma_send_fill_addr,
    dma_send_evict_addr,
    dma_get_fill_data,
    dma_send_evict_data
  } dma_cmd_e;

endpackage

//--- verilog/cache_miss_ctrl.sv
// ********************
// one miss at a time, miss_v_i only while not busy
// ********************

module cache_miss_ctrl (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             miss_v_i,
  input  logic [cache_pkg::addr_width-1:0] miss_addr_i,
  input  logic [cache_pkg::addr_width-1:0] miss_victim_addr_i,
  input  logic [cache_pkg::way_width-1:0]  miss_way_i,
  input  logic                             miss_dirty_i,
  input  logic                             dma_done_i,
  output cache_pkg::dma_cmd_e              dma_cmd_o,
  output logic [cache_pkg::addr_width-1:0] dma_addr_o,
  output logic [cache_pkg::way_width-1:0]  dma_way_o,
  output logic                             miss_busy_o,
  output logic                             miss_done_o
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_evict_addr,
    s_evict_data,
    s_fill_addr,
    s_fill_data
  } state_e;

  state_e state_r;
  state_e state_n;
  logic [addr_width-1:0] addr_r;
  logic [addr_width-1:0] victim_r;
  logic [way_width-1:0] way_r;
  logic done_r;

  always_comb begin
    state_n = state_r;
    dma_cmd_o = dma_nop;
    case (state_r)
      s_idle: begin
        // dirty victim goes out before the fill
        if (miss_v_i) begin
          state_n = miss_dirty_i ? s_evict_addr : s_fill_addr;
        end
      end
      s_evict_addr: begin
        dma_cmd_o = dma_send_evict_addr;
        if (dma_done_i) begin
          state_n = s_evict_data;
        end
      end
      s_evict_data: begin
        dma_cmd_o = dma_send_evict_data;
        if (dma_done_i) begin
          state_n = s_fill_addr;
        end
      end
      s_fill_addr: begin
        dma_cmd_o = dma_send_fill_addr;
        if (dma_done_i) begin
          state_n = s_fill_data;
        end
      end
      s_fill_data: begin
        dma_cmd_o = dma_get_fill_data;
        if (dma_done_i) begin
          state_n = s_idle;
        end
      end
      default: state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_idle;
      done_r <= 1'b0;
    end else begin
      state_r <= state_n;
      // one cycle late so the snoop register has the last word
      done_r <= (state_r == s_fill_data) && dma_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == s_idle) && miss_v_i) begin
      addr_r <= miss_addr_i;
      victim_r <= miss_victim_addr_i;
      way_r <= miss_way_i;
    end
  end

  // victim address only during the two evict steps
  assign dma_addr_o = ((state_r == s_evict_addr) || (state_r == s_evict_data)) ?
                      victim_r : addr_r;
  assign dma_way_o = way_r;
  assign miss_busy_o = (state_r != s_idle);
  assign miss_done_o = done_r;

  a_no_miss_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_v_i |-> !miss_busy_o);

  // the engine only finishes a step that was asked for
  a_done_needs_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_done_i |-> (dma_cmd_o != dma_nop));

endmodule

//--- verilog/dma_fifo.sv
// ********************
// els entries of one word, no bypass from input to output
// ********************

module dma_fifo #(
  parameter int els = 4
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic [cache_pkg::word_width-1:0] data_i,
  input  logic                             v_i,
  output logic                             ready_o,
  output logic [cache_pkg::word_width-1:0] data_o,
  output logic                             v_o,
  input  logic                             yumi_i
);

  localparam int ptr_width = (els > 1) ? $clog2(els) : 1;
  localparam int cnt_width = $clog2(els + 1);

  logic [$bits(data_i)-1:0] mem_r [els];
  logic [ptr_width-1:0] wr_ptr_r;
  logic [ptr_width-1:0] rd_ptr_r;
  logic [cnt_width-1:0] count_r;
  logic wr_en;

  assign ready_o = (count_r != cnt_width'(els));
  assign v_o = (count_r != '0);
  assign data_o = mem_r[rd_ptr_r];
  assign wr_en = v_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width'(els - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (yumi_i) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width'(els - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_r + cnt_width'(wr_en) - cnt_width'(yumi_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

//--- verilog/cache_dma.sv
// ********************
// dma_cmd_i, dma_addr_i and dma_way_i must hold until done_o
// whole-block evictions only, one word per beat
// ********************

module cache_dma (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  cache_pkg::dma_cmd_e                       dma_cmd_i,
  input  logic [cache_pkg::addr_width-1:0]          dma_addr_i,
  input  logic [cache_pkg::way_width-1:0]           dma_way_i,
  output logic                                      done_o,
  output logic [cache_pkg::word_width-1:0]          snoop_word_o,
  output logic                                      dma_pkt_v_o,
  output logic                                      dma_pkt_write_o,
  output logic [cache_pkg::addr_width-1:0]          dma_pkt_addr_o,
  input  logic                                      dma_pkt_yumi_i,
  input  logic                                      in_v_i,
  input  logic [cache_pkg::word_width-1:0]          in_data_i,
  output logic                                      in_yumi_o,
  output logic                                      out_v_o,
  output logic [cache_pkg::word_width-1:0]          out_data_o,
  input  logic                                      out_ready_i,
  output logic                                      mem_v_o,
  output logic                                      mem_w_o,
  output logic [cache_pkg::mem_addr_width-1:0]      mem_addr_o,
  output logic [cache_pkg::ways-1:0]                mem_w_mask_o,
  output logic [cache_pkg::word_width-1:0]          mem_data_o,
  input  logic [cache_pkg::ways-1:0][cache_pkg::word_width-1:0] mem_data_i
);
  import cache_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_fill,
    s_evict
  } state_e;

  state_e state_r;
  state_e state_n;
  logic [count_width-1:0] counter_r;
  logic counter_clear;
  logic counter_up;
  logic pkt_sent_r;
  logic fill_last;
  logic evict_last;
  logic snoop_we;

  assign fill_last = (counter_r == count_width'(block_words - 1));
  assign evict_last = (counter_r == count_width'(block_words));

  // request packet, offset bits cleared
  assign dma_pkt_addr_o = {dma_addr_i[addr_width-1:block_offset_width],
                           {block_offset_width{1'b0}}};
  assign dma_pkt_write_o = (dma_cmd_i == dma_send_evict_addr);
  assign dma_pkt_v_o = (state_r == s_idle) && !pkt_sent_r &&
                       ((dma_cmd_i == dma_send_fill_addr) ||
                        (dma_cmd_i == dma_send_evict_addr));

  assign mem_addr_o = {dma_addr_i[block_offset_width +: set_width],
                       counter_r[word_offset_width-1:0]};
  assign mem_w_mask_o = ways'(1) << dma_way_i;
  assign mem_data_o = in_data_i;
  assign out_data_o = mem_data_i[dma_way_i];

  always_comb begin
    state_n = state_r;
    counter_clear = 1'b0;
    counter_up = 1'b0;
    mem_v_o = 1'b0;
    mem_w_o = 1'b0;
    in_yumi_o = 1'b0;
    out_v_o = 1'b0;
    done_o = pkt_sent_r;
    case (state_r)
      s_idle: begin
        if (dma_cmd_i == dma_get_fill_data) begin
          counter_clear = 1'b1;
          state_n = s_fill;
        end else if (dma_cmd_i == dma_send_evict_data) begin
          // first row read on the way out of idle
          counter_clear = 1'b1;
          counter_up = 1'b1;
          mem_v_o = 1'b1;
          state_n = s_evict;
        end
      end
      s_fill: begin
        mem_v_o = in_v_i;
        mem_w_o = in_v_i;
        in_yumi_o = in_v_i;
        counter_up = in_v_i && !fill_last;
        counter_clear = in_v_i && fill_last;
        done_o = in_v_i && fill_last;
        if (in_v_i && fill_last) begin
          state_n = s_idle;
        end
      end
      s_evict: begin
        // array output holds the row read last, so it is always valid here
        out_v_o = 1'b1;
        mem_v_o = out_ready_i && !evict_last;
        counter_up = out_ready_i && !evict_last;
        counter_clear = out_ready_i && evict_last;
        done_o = out_ready_i && evict_last;
        if (out_ready_i && evict_last) begin
          state_n = s_idle;
        end
      end
      default: state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_idle;
      counter_r <= '0;
      pkt_sent_r <= 1'b0;
    end else begin
      state_r <= state_n;
      pkt_sent_r <= dma_pkt_v_o && dma_pkt_yumi_i;
      if (counter_clear) begin
        counter_r <= count_width'(counter_up);
      end else if (counter_up) begin
        counter_r <= counter_r + count_width'(1);
      end
    end
  end

  // grab the requested word as it streams past
  assign snoop_we = (state_r == s_fill) && in_v_i &&
                    (counter_r[word_offset_width-1:0] ==
                     dma_addr_i[byte_offset_width +: word_offset_width]);

  always_ff @(posedge clk_i) begin
    if (snoop_we) begin
      snoop_word_o <= in_data_i;
    end
  end

  a_cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    ((state_r != s_idle) || dma_pkt_v_o) && !done_o |=> $stable(dma_cmd_i));

endmodule

//--- verilog/cache_data_mem.sv
// ********************
// no access is performed while reset_i is high
// ********************

module cache_data_mem (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 v_i,
  input  logic                                 w_i,
  input  logic [cache_pkg::mem_addr_width-1:0] addr_i,
  input  logic [cache_pkg::ways-1:0]           w_mask_i,
  input  logic [cache_pkg::word_width-1:0]     data_i,
  output logic [cache_pkg::ways-1:0][cache_pkg::word_width-1:0] data_o
);
  import cache_pkg::*;

  localparam int rows = sets * block_words;

  logic access;

  assign access = v_i && !reset_i;

  for (genvar w = 0; w < ways; w++) begin : g_way
    logic [word_width-1:0] mem_r [rows];
    logic [word_width-1:0] rd_r;

    // read data holds until the next read
    always_ff @(posedge clk_i) begin
      if (access) begin
        if (w_i) begin
          if (w_mask_i[w]) begin
            mem_r[addr_i] <= data_i;
          end
        end else begin
          rd_r <= mem_r[addr_i];
        end
      end
    end

    assign data_o[w] = rd_r;
  end

  // fill writes land in exactly one way
  a_one_way_write: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_i && w_i) |-> $onehot(w_mask_i));

endmodule

//--- verilog/cache_miss_top.sv
// ********************
// input FIFO of 4 words, output FIFO of 2 words
// ********************

module cache_miss_top (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             miss_v_i,
  input  logic [cache_pkg::addr_width-1:0] miss_addr_i,
  input  logic [cache_pkg::way_width-1:0]  miss_way_i,
  input  logic                             miss_dirty_i,
  input  logic [cache_pkg::addr_width-1:0] miss_victim_addr_i,
  output logic                             miss_busy_o,
  output logic                             miss_done_o,
  output logic                             dma_pkt_v_o,
  output logic                             dma_pkt_write_o,
  output logic [cache_pkg::addr_width-1:0] dma_pkt_addr_o,
  input  logic                             dma_pkt_yumi_i,
  input  logic [cache_pkg::word_width-1:0] dma_data_i,
  input  logic                             dma_data_v_i,
  output logic                             dma_data_ready_o,
  output logic [cache_pkg::word_width-1:0] dma_data_o,
  output logic                             dma_data_v_o,
  input  logic                             dma_data_yumi_i,
  output logic [cache_pkg::word_width-1:0] load_word_o
);
  import cache_pkg::*;

  dma_cmd_e dma_cmd;
  logic [addr_width-1:0] dma_addr;
  logic [way_width-1:0] dma_way;
  logic dma_done;
  logic in_v;
  logic [word_width-1:0] in_data;
  logic in_yumi;
  logic out_v;
  logic [word_width-1:0] out_data;
  logic out_ready;
  logic mem_v;
  logic mem_w;
  logic [mem_addr_width-1:0] mem_addr;
  logic [ways-1:0] mem_w_mask;
  logic [word_width-1:0] mem_wdata;
  logic [ways-1:0][word_width-1:0] mem_rdata;

  cache_miss_ctrl ctrl (
    .clk_i, .reset_i, .miss_v_i, .miss_addr_i, .miss_victim_addr_i,
    .miss_way_i, .miss_dirty_i, .dma_done_i(dma_done), .dma_cmd_o(dma_cmd),
    .dma_addr_o(dma_addr), .dma_way_o(dma_way), .miss_busy_o, .miss_done_o
  );

  cache_dma dma (
    .clk_i, .reset_i, .dma_cmd_i(dma_cmd), .dma_addr_i(dma_addr),
    .dma_way_i(dma_way), .done_o(dma_done), .snoop_word_o(load_word_o),
    .dma_pkt_v_o, .dma_pkt_write_o, .dma_pkt_addr_o, .dma_pkt_yumi_i,
    .in_v_i(in_v), .in_data_i(in_data), .in_yumi_o(in_yumi),
    .out_v_o(out_v), .out_data_o(out_data), .out_ready_i(out_ready),
    .mem_v_o(mem_v), .mem_w_o(mem_w), .mem_addr_o(mem_addr),
    .mem_w_mask_o(mem_w_mask), .mem_data_o(mem_wdata), .mem_data_i(mem_rdata)
  );

  // fill words from memory
  dma_fifo #(.els(4)) in_fifo (
    .clk_i, .reset_i, .data_i(dma_data_i), .v_i(dma_data_v_i),
    .ready_o(dma_data_ready_o), .data_o(in_data), .v_o(in_v), .yumi_i(in_yumi)
  );

  // eviction words to memory
  dma_fifo #(.els(2)) out_fifo (
    .clk_i, .reset_i, .data_i(out_data), .v_i(out_v), .ready_o(out_ready),
    .data_o(dma_data_o), .v_o(dma_data_v_o), .yumi_i(dma_data_yumi_i)
  );

  cache_data_mem data_mem (
    .clk_i, .reset_i, .v_i(mem_v), .w_i(mem_w), .addr_i(mem_addr),
    .w_mask_i(mem_w_mask), .data_i(mem_wdata), .data_o(mem_rdata)
  );

endmodule

//--- test/cache_miss_tb.sv
// ********************
// run from the project root, misses come from test/miss_vectors.txt
// memory word at byte address A is A xor 0x5A5A0000
// ********************

module cache_miss_tb;
  import cache_pkg::*;

  localparam int timeout_cycles = 2000;
  localparam int seed = 19381;
  localparam int fields = 9;

  logic clk_i = 1'b0;
  logic reset_i;
  logic miss_v_i;
  logic [addr_width-1:0] miss_addr_i;
  logic [way_width-1:0] miss_way_i;
  logic miss_dirty_i;
  logic [addr_width-1:0] miss_victim_addr_i;
  logic miss_busy_o;
  logic miss_done_o;
  logic dma_pkt_v_o;
  logic dma_pkt_write_o;
  logic [addr_width-1:0] dma_pkt_addr_o;
  logic dma_pkt_yumi_i = 1'b0;
  logic [word_width-1:0] dma_data_i = '0;
  logic dma_data_v_i = 1'b0;
  logic dma_data_ready_o;
  logic [word_width-1:0] dma_data_o;
  logic dma_data_v_o;
  logic dma_data_yumi_i = 1'b0;
  logic [word_width-1:0] load_word_o;

  logic [31:0] vec_mem [0:127];
  logic pkt_write_q [$];
  logic [addr_width-1:0] pkt_addr_q [$];
  logic [word_width-1:0] fill_q [$];
  logic [word_width-1:0] evict_q [$];
  int done_total = 0;
  int errors = 0;
  int timeouts = 0;

  cache_miss_top cache_miss_top_i (
    .clk_i, .reset_i, .miss_v_i, .miss_addr_i, .miss_way_i, .miss_dirty_i,
    .miss_victim_addr_i, .miss_busy_o, .miss_done_o, .dma_pkt_v_o,
    .dma_pkt_write_o, .dma_pkt_addr_o, .dma_pkt_yumi_i, .dma_data_i,
    .dma_data_v_i, .dma_data_ready_o, .dma_data_o, .dma_data_v_o,
    .dma_data_yumi_i, .load_word_o
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [word_width-1:0] memory_word(input logic [addr_width-1:0] byte_addr);
    return byte_addr ^ 32'h5A5A_0000;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("error: %s is %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic wait_until_idle();
    int cycles;
    cycles = 0;
    while (miss_busy_o && (cycles < timeout_cycles)) begin
      @(negedge clk_i);
      cycles++;
    end
    if (miss_busy_o) begin
      $display("timeout: the miss controller never went idle");
      timeouts++;
    end
  endtask

  task automatic poll_miss_done();
    int cycles;
    cycles = 0;
    while (!miss_done_o && (cycles < timeout_cycles)) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!miss_done_o) begin
      $display("timeout: the miss never signalled completion");
      timeouts++;
    end
  endtask

  task automatic drain_evictions(input int target);
    int cycles;
    cycles = 0;
    while ((evict_q.size() < target) && (cycles < timeout_cycles)) begin
      @(negedge clk_i);
      cycles++;
    end
    if (evict_q.size() < target) begin
      $display("timeout: eviction words did not all reach memory");
      timeouts++;
    end
  endtask

  // memory model with random gaps on all three channels
  always @(posedge clk_i) begin
    if (reset_i) begin
      dma_pkt_yumi_i <= 1'b0;
      dma_data_v_i <= 1'b0;
      dma_data_yumi_i <= 1'b0;
    end else begin
      if (dma_pkt_v_o && dma_pkt_yumi_i) begin
        pkt_write_q.push_back(dma_pkt_write_o);
        pkt_addr_q.push_back(dma_pkt_addr_o);
        if (!dma_pkt_write_o) begin
          for (int k = 0; k < block_words; k++) begin
            fill_q.push_back(memory_word(dma_pkt_addr_o + 32'(4 * k)));
          end
        end
        dma_pkt_yumi_i <= 1'b0;
      end else begin
        dma_pkt_yumi_i <= dma_pkt_v_o && ($urandom_range(2) != 0);
      end
      // fill words, next one offered after a random gap
      if (dma_data_v_i && dma_data_ready_o) begin
        void'(fill_q.pop_front());
      end
      if ((fill_q.size() > 0) && ($urandom_range(3) != 0)) begin
        dma_data_v_i <= 1'b1;
        dma_data_i <= fill_q[0];
      end else begin
        dma_data_v_i <= 1'b0;
      end
      // no yumi right after a pop, the FIFO may have emptied
      if (dma_data_v_o && dma_data_yumi_i) begin
        evict_q.push_back(dma_data_o);
        dma_data_yumi_i <= 1'b0;
      end else begin
        dma_data_yumi_i <= dma_data_v_o && ($urandom_range(2) != 0);
      end
      if (miss_done_o) begin
        done_total++;
      end
    end
  end

  initial begin
    int num_vectors;
    int base;
    int n_pkts;
    int n_words;
    int pkt_start;
    int evict_start;
    int done_start;
    logic [addr_width-1:0] addr;
    logic [addr_width-1:0] victim;
    logic dirty;

    void'($urandom(seed));
    reset_i = 1'b1;
    miss_v_i = 1'b0;
    miss_addr_i = '0;
    miss_way_i = '0;
    miss_dirty_i = 1'b0;
    miss_victim_addr_i = '0;
    $readmemh("test/miss_vectors.txt", vec_mem);
    num_vectors = int'(vec_mem[0]);
    if (num_vectors == 0) begin
      $display("no misses were read from test/miss_vectors.txt");
      errors++;
    end

    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("miss_busy_o", 32'(miss_busy_o), 32'h0);
    check_value("miss_done_o", 32'(miss_done_o), 32'h0);
    check_value("dma_pkt_v_o", 32'(dma_pkt_v_o), 32'h0);
    check_value("dma_data_v_o", 32'(dma_data_v_o), 32'h0);
    check_value("dma_data_ready_o", 32'(dma_data_ready_o), 32'h1);

    for (int i = 0; (i < num_vectors) && (timeouts == 0); i++) begin
      base = 1 + fields * i;
      addr = vec_mem[base];
      dirty = vec_mem[base + 2][0];
      victim = vec_mem[base + 3];
      n_pkts = dirty ? 2 : 1;
      n_words = dirty ? block_words : 0;
      wait_until_idle();
      if (timeouts != 0) begin
        break;
      end
      pkt_start = pkt_addr_q.size();
      evict_start = evict_q.size();
      done_start = done_total;

      @(posedge clk_i);
      miss_v_i <= 1'b1;
      miss_addr_i <= addr;
      miss_way_i <= vec_mem[base + 1][way_width-1:0];
      miss_dirty_i <= dirty;
      miss_victim_addr_i <= victim;
      @(posedge clk_i);
      miss_v_i <= 1'b0;
      @(negedge clk_i);

      poll_miss_done();
      check_value("load_word_o", load_word_o, vec_mem[base + 4]);
      drain_evictions(evict_start + n_words);
      repeat (2) @(negedge clk_i);

      // write packet for the victim first, then the read
      check_value("dma_pkt_v_o accepts", 32'(pkt_addr_q.size() - pkt_start), 32'(n_pkts));
      if (pkt_addr_q.size() == pkt_start + n_pkts) begin
        if (dirty) begin
          check_value("dma_pkt_write_o", 32'(pkt_write_q[pkt_start]), 32'h1);
          check_value("dma_pkt_addr_o", pkt_addr_q[pkt_start], victim & 32'hFFFF_FFF0);
        end
        check_value("dma_pkt_write_o", 32'(pkt_write_q[pkt_start + n_pkts - 1]), 32'h0);
        check_value("dma_pkt_addr_o", pkt_addr_q[pkt_start + n_pkts - 1],
                    addr & 32'hFFFF_FFF0);
      end
      check_value("dma_data_o words", 32'(evict_q.size() - evict_start), 32'(n_words));
      if (evict_q.size() == evict_start + n_words) begin
        for (int k = 0; k < n_words; k++) begin
          check_value("dma_data_o", evict_q[evict_start + k], vec_mem[base + 5 + k]);
        end
      end
      check_value("dma_data_i words left", 32'(fill_q.size()), 32'h0);
      check_value("miss_done_o pulses", 32'(done_total - done_start), 32'h1);
    end

    $display("%0d mismatches, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- test/miss_vectors.txt
// first value is the number of misses, then one miss per line, all hex
// addr way dirty victim_addr load_word evict0 evict1 evict2 evict3
0b
00001234 0 0 00000000 5a5a1234 00000000 00000000 00000000 00000000
00002238 1 0 00000000 5a5a2238 00000000 00000000 00000000 00000000
0000433c 0 1 00001230 5a5a433c 5a5a1230 5a5a1234 5a5a1238 5a5a123c
00005330 1 1 00002230 5a5a5330 5a5a2230 5a5a2234 5a5a2238 5a5a223c
80000a44 0 0 00000000 da5a0a44 00000000 00000000 00000000 00000000
12345648 1 0 00000000 486e5648 00000000 00000000 00000000 00000000
0000f04c 0 1 80000a40 5a5af04c da5a0a40 da5a0a44 da5a0a48 da5a0a4c
abcd1044 1 1 12345640 f1971044 486e5640 486e5644 486e5648 486e564c
00000000 0 0 00000000 5a5a0000 00000000 00000000 00000000 00000000
00007008 0 1 00000000 5a5a7008 5a5a0000 5a5a0004 5a5a0008 5a5a000c
0000903c 0 1 00004330 5a5a903c 5a5a4330 5a5a4334 5a5a4338 5a5a433c

//--- project.f
verilog/cache_pkg.sv
verilog/cache_miss_ctrl.sv
verilog/dma_fifo.sv
verilog/cache_dma.sv
verilog/cache_data_mem.sv
verilog/cache_miss_top.sv
test/cache_miss_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache miss testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --top-module cache_miss_tb -f project.f \
  --Mdir obj_dir -o cache_miss_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cache_miss_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
